//--- hw/dc2_bank.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_bank import dc2_pkg::*; #(
  parameter int WAY  = 0,
  parameter int BANK = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  arr_cmd_t cmd,
  input  ben_t     ben,
  input  word_t    wr_word,
  output word_t    rd_word,
  output logic     rd_hit
);

  logic  hit;
  logic  en_even, en_odd;
  logic  wen_even, wen_odd;
  logic  rd_hit_q;
  logic  odd_q;
  word_t rdata_even, rdata_odd;

  assign hit = cmd.way[WAY];

  assign en_even  = (cmd.rd | cmd.wr) & ~cmd.odd;
  assign en_odd   = (cmd.rd | cmd.wr) & cmd.odd;
  assign wen_even = cmd.wr & hit & ~cmd.odd & (|ben);
  assign wen_odd  = cmd.wr & hit & cmd.odd & (|ben);

  dc2_word_ram ram_even_i (
    .clk   (clk),
    .rst   (rst),
    .en    (en_even),
    .set   (cmd.set),
    .wen   (wen_even),
    .ben   (ben),
    .wdata (wr_word),
    .rdata (rdata_even)
  );

  dc2_word_ram ram_odd_i (
    .clk   (clk),
    .rst   (rst),
    .en    (en_odd),
    .set   (cmd.set),
    .wen   (wen_odd),
    .ben   (ben),
    .wdata (wr_word),
    .rdata (rdata_odd)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_hit_q <= 1'b0;
      odd_q    <= 1'b0;
    end else begin
      rd_hit_q <= cmd.rd & hit;
      odd_q    <= cmd.odd;
    end
  end

  // unselected ways give zero so the line can be ORed
  assign rd_word = rd_hit_q ? (odd_q ? rdata_odd : rdata_even) : '0;

  // way hit comes out of bank 0 only
  assign rd_hit = (BANK == 0) ? rd_hit_q : 1'b0;

endmodule

//--- hw/dc2_macros.svh
`ifndef DC2_MACROS_SVH
`define DC2_MACROS_SVH

// array geometry
`define DC2_NUM_WAYS   2
`define DC2_NUM_BANKS  4

`define DC2_SET_W      6
`define DC2_SETS       (1 << `DC2_SET_W)

`define DC2_BANK_IDX_W 2

// bank word
`define DC2_WORD_W     32
`define DC2_BYTES      4

`endif

//--- hw/dc2_pkg.sv
`include "dc2_macros.svh"

package dc2_pkg;

  typedef logic [`DC2_SET_W-1:0]                  set_t;
  typedef logic [`DC2_BANK_IDX_W-1:0]             bank_idx_t;
  typedef logic [`DC2_NUM_WAYS-1:0]               way_mask_t; // one-hot
  typedef logic [`DC2_NUM_BANKS-1:0]              bank_mask_t;
  typedef logic [`DC2_BYTES-1:0]                  ben_t;
  typedef logic [`DC2_WORD_W-1:0]                 word_t;
  typedef logic [`DC2_NUM_BANKS*`DC2_WORD_W-1:0]  line_t;     // bank i at word i
  typedef logic [`DC2_NUM_BANKS*`DC2_BYTES-1:0]   ben_vec_t;

  typedef struct packed {
    logic      en;
    logic      odd;
    set_t      set;
    way_mask_t way;
  } rd_req_t;

  typedef struct packed {
    logic       en;
    logic       odd;
    set_t       set;
    way_mask_t  way;
    bank_mask_t bank_en;
    bank_idx_t  begin_bank;
    bank_idx_t  end_bank;
    ben_t       begin_ben;
    ben_t       end_ben;
  } wr_req_t;

  // merged command into the array
  typedef struct packed {
    logic      rd;
    logic      wr;
    logic      odd;
    set_t      set;
    way_mask_t way;
  } arr_cmd_t;

endpackage

//--- hw/dc2_read_out.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_read_out import dc2_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  line_t [`DC2_NUM_WAYS-1:0]  way_words,
  input  way_mask_t                  hit_ways,
  input  logic                       rd_pend,
  output line_t                      read_data,
  output logic                       read_hit,
  output logic                       read_valid
);

  line_t line_or;
  logic  pend_q;  // lines up with the RAM read

  always_comb begin
    line_or = '0;
    for (int w = 0; w < `DC2_NUM_WAYS; w++) begin
      line_or = line_or | way_words[w];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q     <= 1'b0;
      read_valid <= 1'b0;
      read_hit   <= 1'b0;
    end else begin
      pend_q     <= rd_pend;
      read_valid <= pend_q;
      read_hit   <= |hit_ways;
    end
    read_data <= line_or;
  end

endmodule

//--- hw/dc2_req_stage.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_req_stage import dc2_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  rd_req_t  rd_req,
  input  wr_req_t  wr_req,
  input  line_t    wr_data,
  output arr_cmd_t cmd,
  output ben_vec_t cmd_ben,
  output line_t    cmd_data
);

  ben_vec_t ben_next;
  logic     take_rd;

  // write wins, a colliding read is lost
  assign take_rd = rd_req.en & ~wr_req.en;

  // begin bank first, then end bank, every other enabled bank gets all bytes
  always_comb begin
    for (int b = 0; b < `DC2_NUM_BANKS; b++) begin
      if (!wr_req.bank_en[b]) begin
        ben_next[b*`DC2_BYTES +: `DC2_BYTES] = '0;
      end else if (bank_idx_t'(b) == wr_req.begin_bank) begin
        ben_next[b*`DC2_BYTES +: `DC2_BYTES] = wr_req.begin_ben;
      end else if (bank_idx_t'(b) == wr_req.end_bank) begin
        ben_next[b*`DC2_BYTES +: `DC2_BYTES] = wr_req.end_ben;
      end else begin
        ben_next[b*`DC2_BYTES +: `DC2_BYTES] = '1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.rd <= 1'b0;
      cmd.wr <= 1'b0;
    end else begin
      cmd.rd <= take_rd;
      cmd.wr <= wr_req.en;
    end
    if (wr_req.en) begin
      cmd.odd <= wr_req.odd;
      cmd.set <= wr_req.set;
      cmd.way <= wr_req.way;
    end else begin
      cmd.odd <= rd_req.odd;
      cmd.set <= rd_req.set;
      cmd.way <= rd_req.way;
    end
    cmd_ben  <= ben_next;
    cmd_data <= wr_data;
  end

endmodule

//--- hw/dc2_top.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_top import dc2_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  rd_req_t rd_req,
  input  wr_req_t wr_req,
  input  line_t   wr_data,
  output line_t   read_data,
  output logic    read_hit,
  output logic    read_valid
);

  arr_cmd_t                  cmd;
  ben_vec_t                  cmd_ben;
  line_t                     cmd_data;
  line_t [`DC2_NUM_WAYS-1:0] way_words;
  bank_mask_t                bank_hit [`DC2_NUM_WAYS];
  way_mask_t                 hit_ways;

  dc2_req_stage req_stage_i (
    .clk      (clk),
    .rst      (rst),
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .wr_data  (wr_data),
    .cmd      (cmd),
    .cmd_ben  (cmd_ben),
    .cmd_data (cmd_data)
  );

  for (genvar w = 0; w < `DC2_NUM_WAYS; w++) begin : g_way
    for (genvar b = 0; b < `DC2_NUM_BANKS; b++) begin : g_bank
      dc2_bank #(
        .WAY  (w),
        .BANK (b)
      ) bank_i (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .ben     (cmd_ben[b*`DC2_BYTES +: `DC2_BYTES]),
        .wr_word (cmd_data[b*`DC2_WORD_W +: `DC2_WORD_W]),
        .rd_word (way_words[w][b*`DC2_WORD_W +: `DC2_WORD_W]),
        .rd_hit  (bank_hit[w][b])
      );
    end
    assign hit_ways[w] = |bank_hit[w];
  end

  dc2_read_out read_out_i (
    .clk        (clk),
    .rst        (rst),
    .way_words  (way_words),
    .hit_ways   (hit_ways),
    .rd_pend    (cmd.rd),
    .read_data  (read_data),
    .read_hit   (read_hit),
    .read_valid (read_valid)
  );

endmodule

//--- hw/dc2_word_ram.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_word_ram import dc2_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  en,
  input  set_t  set,
  input  logic  wen,
  input  ben_t  ben,
  input  word_t wdata,
  output word_t rdata
);

  word_t mem [0:`DC2_SETS-1];
  set_t  addr_q;  // shared read/write address
  logic  wen_q;
  ben_t  ben_q;
  word_t wdata_q;
  word_t merged;

  // read sees the previous edge's write, so write-first
  assign rdata = mem[addr_q];

  always_comb begin
    merged = rdata;
    for (int i = 0; i < `DC2_BYTES; i++) begin
      if (ben_q[i]) merged[i*8 +: 8] = wdata_q[i*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
      wen_q  <= 1'b0;
    end else begin
      if (en) addr_q <= set;  // held otherwise
      wen_q <= en & wen;
    end
    ben_q   <= ben;
    wdata_q <= wdata;
  end

  // second half of the read-modify-write
  always_ff @(posedge clk) begin
    if (wen_q) mem[addr_q] <= merged;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the dc2 testbench, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module dc2_tb -o dc2_sim \
  > sim.log 2>&1 \
  && ./obj_dir/dc2_sim >> sim.log 2>&1 \
  || echo "Test FAILED: build or simulation returned an error" >> sim.log
cat sim.log
if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb.f
+incdir+hw
hw/dc2_pkg.sv
hw/dc2_req_stage.sv
hw/dc2_word_ram.sv
hw/dc2_bank.sv
hw/dc2_read_out.sv
hw/dc2_top.sv
verification/dc2_tb.sv

//--- verification/dc2_tb.sv
`timescale 1ns/1ps
`include "dc2_macros.svh"

module dc2_tb import dc2_pkg::*; ();

  typedef struct packed {
    int    due;   // cycle count when the line must show up
    logic  hit;
    line_t data;
  } exp_rd_t;

  logic    clk;
  logic    rst;
  rd_req_t rd_req;
  wr_req_t wr_req;
  line_t   wr_data;
  line_t   read_data;
  logic    read_hit;
  logic    read_valid;

  integer  seed = 59152;
  int      cyc;
  int      reads_checked;
  exp_rd_t exp_q [$];
  word_t   model_mem [`DC2_NUM_WAYS][2][`DC2_SETS][`DC2_NUM_BANKS];

  dc2_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .wr_data    (wr_data),
    .read_data  (read_data),
    .read_hit   (read_hit),
    .read_valid (read_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic raise_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_line(input line_t got, input line_t exp, input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_hit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // distinct per way, half, set and bank
  function automatic word_t fill_word(input int w, input int h, input int s, input int b);
    return word_t'(32'hc3000011 ^ (w << 22) ^ (h << 20) ^ (s << 8) ^ (b << 2));
  endfunction

  function automatic line_t rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic way_mask_t rand_way();
    logic [31:0] r;
    way_mask_t   m;
    r = $random(seed);
    m = '0;
    if (r[2:0] != 3'd0) m[r[3]] = 1'b1;  // zero mask now and then
    return m;
  endfunction

  function automatic rd_req_t rand_rd_req();
    logic [31:0] r;
    rd_req_t     rq;
    r = $random(seed);
    rq.en = 1'b1;
    rq.odd = r[0];
    rq.set = r[6:1];
    rq.way = rand_way();
    return rq;
  endfunction

  function automatic wr_req_t rand_wr_req();
    logic [31:0] r;
    wr_req_t     wq;
    r = $random(seed);
    wq.en = 1'b1;
    wq.odd = r[0];
    wq.set = r[6:1];
    wq.way = rand_way();
    wq.bank_en = r[10:7];
    wq.begin_bank = r[12:11];
    wq.end_bank = r[14:13];
    wq.begin_ben = r[18:15];
    wq.end_ben = r[22:19];
    return wq;
  endfunction

  // begin bank wins over end bank, other enabled banks write every byte
  function automatic ben_t bank_ben(input wr_req_t wq, input int b);
    if (!wq.bank_en[b]) return '0;
    if (b == int'(wq.begin_bank)) return wq.begin_ben;
    if (b == int'(wq.end_bank)) return wq.end_ben;
    return '1;
  endfunction

  function automatic void model_write(input wr_req_t wq, input line_t d);
    ben_t  be;
    word_t w_new;
    for (int w = 0; w < `DC2_NUM_WAYS; w++) begin
      if (wq.way[w]) begin
        for (int b = 0; b < `DC2_NUM_BANKS; b++) begin
          be = bank_ben(wq, b);
          w_new = model_mem[w][wq.odd][wq.set][b];
          for (int i = 0; i < `DC2_BYTES; i++) begin
            if (be[i]) w_new[i*8 +: 8] = d[b*`DC2_WORD_W + i*8 +: 8];
          end
          model_mem[w][wq.odd][wq.set][b] = w_new;
        end
      end
    end
  endfunction

  // ways outside the mask read as zero
  function automatic line_t model_line(input rd_req_t rq);
    line_t l;
    l = '0;
    for (int w = 0; w < `DC2_NUM_WAYS; w++) begin
      if (rq.way[w]) begin
        for (int b = 0; b < `DC2_NUM_BANKS; b++) begin
          l[b*`DC2_WORD_W +: `DC2_WORD_W] = l[b*`DC2_WORD_W +: `DC2_WORD_W]
                                            | model_mem[w][rq.odd][rq.set][b];
        end
      end
    end
    return l;
  endfunction

  task automatic check_outputs();
    exp_rd_t e;
    if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      check_hit(read_valid, 1'b1, $sformatf("read_valid of read due at cycle %0d", e.due));
      check_hit(read_hit, e.hit, $sformatf("read_hit of read due at cycle %0d", e.due));
      check_line(read_data, e.data, $sformatf("read_data of read due at cycle %0d", e.due));
      reads_checked++;
    end else begin
      check_hit(read_valid, 1'b0, "read_valid with no read outstanding");
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    cyc++;
    check_outputs();
  endtask

  // a colliding read is dropped by the DUT, so nothing is expected for it
  task automatic apply_request(input rd_req_t rq, input wr_req_t wq, input line_t d);
    exp_rd_t e;
    rd_req = rq;
    wr_req = wq;
    wr_data = d;
    if (wq.en) begin
      model_write(wq, d);
    end else if (rq.en) begin
      e.due = cyc + 3;
      e.hit = |rq.way;
      e.data = model_line(rq);
      exp_q.push_back(e);
    end
  endtask

  initial begin
    logic [31:0] r;
    rd_req_t     rq;
    wr_req_t     wq;
    wr_req_t     last_wr;
    line_t       d;
    int          wait_cnt;
    rst = 1'b1;
    rd_req = '0;
    wr_req = '0;
    wr_data = '0;
    cyc = 0;
    reads_checked = 0;
    last_wr = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    repeat (8) begin
      next_cycle();
      apply_request('0, '0, '0);
    end

    // preload every line with full byte enables
    for (int w = 0; w < `DC2_NUM_WAYS; w++) begin
      for (int h = 0; h < 2; h++) begin
        for (int s = 0; s < `DC2_SETS; s++) begin
          next_cycle();
          wq = '0;
          wq.en = 1'b1;
          wq.odd = h[0];
          wq.set = set_t'(s);
          wq.way[w] = 1'b1;
          wq.bank_en = '1;
          wq.end_bank = bank_idx_t'(`DC2_NUM_BANKS - 1);
          wq.begin_ben = '1;
          wq.end_ben = '1;
          for (int b = 0; b < `DC2_NUM_BANKS; b++) begin
            d[b*`DC2_WORD_W +: `DC2_WORD_W] = fill_word(w, h, s, b);
          end
          apply_request('0, wq, d);
        end
      end
    end

    // back to back reads, several in flight
    repeat (64) begin
      next_cycle();
      apply_request(rand_rd_req(), '0, '0);
    end

    repeat (1000) begin
      next_cycle();
      r = $random(seed);
      rq = '0;
      wq = '0;
      d = rand_line();
      if (last_wr.en && r[4]) begin
        rq.en = 1'b1;  // same word as the write just before
        rq.odd = last_wr.odd;
        rq.set = last_wr.set;
        rq.way = last_wr.way;
      end else begin
        case (r[2:0])
          3'd0, 3'd1, 3'd2: wq = rand_wr_req();
          3'd3, 3'd4, 3'd5: rq = rand_rd_req();
          3'd6: begin
            rq = rand_rd_req();
            wq = rand_wr_req();
          end
          default: ;
        endcase
      end
      apply_request(rq, wq, d);
      last_wr = wq;
    end

    // read back the whole array
    for (int w = 0; w < `DC2_NUM_WAYS; w++) begin
      for (int h = 0; h < 2; h++) begin
        for (int s = 0; s < `DC2_SETS; s++) begin
          next_cycle();
          rq = '0;
          rq.en = 1'b1;
          rq.odd = h[0];
          rq.set = set_t'(s);
          rq.way[w] = 1'b1;
          apply_request(rq, '0, '0);
        end
      end
    end

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 20) begin
      next_cycle();
      apply_request('0, '0, '0);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      raise_error("timeout while waiting for outstanding reads to return");
    end else begin
      $display("%0d reads checked", reads_checked);
      $display("Test OK");
      $finish;
    end
  end

endmodule
